// ==== filelist.f ====
logic/edpPkg.sv
logic/uwordDecode.sv
logic/adderPair.sv
logic/regBank.sv
logic/fastMem.sv
logic/dataPath.sv
test/dataPathTb.sv

// ==== Makefile ====
TOOL      = verilator
LINTFLAGS = --lint-only -Wall --timing
SIMFLAGS  = --binary --timing --assert
TOP       = dataPathTb
FILELIST  = filelist.f
OBJDIR    = obj_dir
PASSMSG   = ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# Fails unless the run prints the pass message
sim:
	$(TOOL) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASSMSG)'

clean:
	rm -rf $(OBJDIR)

// ==== test/dataPathTb.sv ====
module dataPathTb
  import edpPkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam word_t leftMask = {{halfW{1'b1}}, {halfW{1'b0}}};
  localparam word_t signBit = {1'b1, {(wordW - 1){1'b0}}};
  // Reset, then tests 1 to 6 in cycles
  localparam int testCycles = 10 + 1 + 29 + 36 + 20 + 38 + 35;
  localparam int cycleLimit = 2 * testCycles;

  logic      clk = 1'b0;
  logic      arstN;
  logic      step;
  uword_u    uword;
  word_t     extData;
  regView_t  regs;
  edpFlags_t flags;
  word_t     ebusData;
  logic      ebusValid;
  logic      fmParity;

  logic [31:0] lfsrState = 32'h1c8a_9449;
  int          cycles = 0;
  int          errors = 0;
  int          checks = 0;
  int          testsPassed = 0;
  int          testsFailed = 0;

  // Reference state
  regView_t  expRegs;
  edpFlags_t expFlags;
  word_t     expFm [fmDepth];

  dataPath dataPath_i (
    .clk       (clk),
    .arstN     (arstN),
    .step      (step),
    .uword     (uword),
    .extData   (extData),
    .regs      (regs),
    .flags     (flags),
    .ebusData  (ebusData),
    .ebusValid (ebusValid),
    .fmParity  (fmParity)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
      $display("** FAIL **");
      $finish;
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  function automatic word_t randWord();
    word_t w;
    w = '0;
    for (int i = 0; i < wordW; i++) begin
      w = {w[1:wordW-1], lfsrBit()};
    end
    return w;
  endfunction

  function automatic uword_u opWord(adFunc_e f, adaSel_e a, adbSel_e b, arSel_e ar,
                                    arxSel_e arx, mqFunc_e mq);
    uword_u u;
    u = '0;
    u.normal.adFunc = f;
    u.normal.adaSel = a;
    u.normal.adbSel = b;
    u.normal.arSel = ar;
    u.normal.arxSel = arx;
    u.normal.mqFunc = mq;
    return u;
  endfunction

  function automatic uword_u diagWord(diagSrc_e src, logic [fmAdrW-1:0] adr);
    uword_u u;
    u = '0;
    u.diag.fmt = 1'b1;
    u.diag.diagSrc = src;
    u.diag.fmAdr = adr;
    return u;
  endfunction

  // Carry into bit 0 recovered from the sum bit
  function automatic edpFlags_t addFlags(word_t a, word_t b, logic cin);
    logic [wordW:0] full;
    edpFlags_t fl;
    full = {1'b0, a} + {1'b0, b} + (wordW + 1)'(cin);
    fl.cry0 = full[wordW];
    fl.cry1 = full[wordW-1] ^ a[0] ^ b[0];
    fl.ovf = fl.cry0 ^ fl.cry1;
    return fl;
  endfunction

  function automatic edpFlags_t aluFlags(adFunc_e f, word_t a, word_t b);
    case (f)
      fnAdd:    return addFlags(a, b, 1'b0);
      fnAddOne: return addFlags(a, b, 1'b1);
      fnSub:    return addFlags(a, ~b, 1'b1);
      default:  return '0;
    endcase
  endfunction

  function automatic word_t aluResult(adFunc_e f, word_t a, word_t b);
    case (f)
      fnAdd:    return a + b;
      fnAddOne: return a + b + word_t'(1);
      fnSub:    return a - b;
      fnAnd:    return a & b;
      fnOr:     return a | b;
      fnXor:    return a ^ b;
      fnPassA:  return a;
      default:  return b;
    endcase
  endfunction

  task automatic checkWord(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkRegs(regView_t got, regView_t exp);
    checkWord("ar", got.ar, exp.ar);
    checkWord("arx", got.arx, exp.arx);
    checkWord("br", got.br, exp.br);
    checkWord("brx", got.brx, exp.brx);
    checkWord("mq", got.mq, exp.mq);
  endtask

  task automatic checkFlags(edpFlags_t got, edpFlags_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] flags {cry0,cry1,ovf}: got 0x%h, expected 0x%h", got, exp);
    end
  endtask

  task automatic finishTest(string name, int errBefore);
    if (errors == errBefore) begin
      testsPassed++;
      $display("test %s: ok", name);
    end else begin
      testsFailed++;
      $display("test %s: %0d mismatches", name, errors - errBefore);
    end
  endtask

  // One strobe, sampled on the next edge, results checked at the negedge
  task automatic runStep(uword_u u, word_t d);
    @(posedge clk);
    step <= 1'b1;
    uword <= u;
    extData <= d;
    @(posedge clk);
    step <= 1'b0;
    @(negedge clk);
  endtask

  task automatic loadAr(word_t v);
    runStep(opWord(fnPassA, adaAR, adbBR, arExt, arxHold, mqHold), v);
    expRegs.ar = v;
    expFlags = '0;
  endtask

  task automatic loadArx(word_t v);
    runStep(opWord(fnPassA, adaAR, adbBR, arHold, arxExt, mqHold), v);
    expRegs.arx = v;
    expFlags = '0;
  endtask

  // BR takes the old AR while AR loads the new word
  task automatic loadBrAr(word_t v);
    uword_u u;
    u = opWord(fnPassA, adaAR, adbBR, arExt, arxHold, mqHold);
    u.normal.brLoad = 1'b1;
    runStep(u, v);
    expRegs.br = expRegs.ar;
    expRegs.ar = v;
    expFlags = '0;
  endtask

  // Valid for exactly the cycle after the strobe
  task automatic diagRead(diagSrc_e src, logic [fmAdrW-1:0] adr, word_t exp, string name);
    runStep(diagWord(src, adr), '0);
    checkBit("ebusValid", ebusValid, 1'b1);
    checkWord(name, ebusData, exp);
    @(negedge clk);
    checkBit("ebusValid", ebusValid, 1'b0);
  endtask

  task automatic resetTest();
    int errBefore;
    errBefore = errors;
    expRegs = '0;
    expFlags = '0;
    checkRegs(regs, expRegs);
    checkFlags(flags, expFlags);
    checkBit("ebusValid", ebusValid, 1'b0);
    finishTest("reset", errBefore);
  endtask

  task automatic loadMoveTest();
    int errBefore;
    word_t x [5];
    uword_u u;
    errBefore = errors;
    for (int i = 0; i < 5; i++) begin
      x[i] = randWord();
    end
    loadAr(x[0]);
    loadArx(x[1]);
    u = opWord(fnPassA, adaAR, adbBR, arAD, arxHold, mqHold);
    u.normal.brLoad = 1'b1;
    u.normal.brxLoad = 1'b1;
    runStep(u, '0);
    expRegs.br = expRegs.ar;
    expRegs.brx = expRegs.arx;
    checkRegs(regs, expRegs);
    checkFlags(flags, expFlags);
    loadAr(x[2]);
    runStep(opWord(fnPassA, adaAR, adbBR, arHold, arxHold, mqLoad), '0);
    expRegs.mq = expRegs.ar;
    loadAr(x[3]);
    loadArx(x[4]);
    checkRegs(regs, expRegs);
    diagRead(dsAR, 4'd0, expRegs.ar, "ebusData (AR)");
    diagRead(dsARX, 4'd0, expRegs.arx, "ebusData (ARX)");
    diagRead(dsBR, 4'd0, expRegs.br, "ebusData (BR)");
    diagRead(dsBRX, 4'd0, expRegs.brx, "ebusData (BRX)");
    diagRead(dsMQ, 4'd0, expRegs.mq, "ebusData (MQ)");
    checkRegs(regs, expRegs);
    checkFlags(flags, expFlags);
    finishTest("load and diagnostic read", errBefore);
  endtask

  task automatic aluTest();
    int errBefore;
    adFunc_e ops [6];
    word_t a;
    word_t b;
    errBefore = errors;
    ops = '{fnAdd, fnSub, fnAnd, fnOr, fnXor, fnAdd};
    for (int i = 0; i < 6; i++) begin
      a = randWord();
      b = randWord();
      // Last add overflows into the sign bit
      if (i == 5) begin
        a = 36'h4_0000_0000;
        b = a;
      end
      loadAr(b);
      loadBrAr(a);
      runStep(opWord(ops[i], adaAR, adbBR, arAD, arxHold, mqHold), '0);
      expRegs.ar = aluResult(ops[i], a, b);
      expFlags = aluFlags(ops[i], a, b);
      checkRegs(regs, expRegs);
      checkFlags(flags, expFlags);
    end
    finishTest("single word ALU", errBefore);
  endtask

  task automatic longAddTest();
    int errBefore;
    word_t hiA;
    word_t loA;
    word_t hiB;
    word_t loB;
    logic [2*wordW:0] full;
    uword_u u;
    errBefore = errors;
    for (int i = 0; i < 2; i++) begin
      hiA = randWord();
      loA = randWord();
      hiB = randWord();
      loB = randWord();
      // Low halves that must carry into AD
      if (i == 0) begin
        loA = '1;
        loB = loB | word_t'(1);
      end
      loadAr(hiB);
      loadArx(loB);
      u = opWord(fnPassA, adaAR, adbBR, arExt, arxHold, mqHold);
      u.normal.brLoad = 1'b1;
      u.normal.brxLoad = 1'b1;
      runStep(u, hiA);
      expRegs.br = expRegs.ar;
      expRegs.brx = expRegs.arx;
      expRegs.ar = hiA;
      loadArx(loA);
      u = opWord(fnAdd, adaAR, adbBR, arAD, arxADX, mqHold);
      u.normal.long = 1'b1;
      runStep(u, '0);
      full = {1'b0, hiA, loA} + {1'b0, hiB, loB};
      expRegs.ar = full[2*wordW-1:wordW];
      expRegs.arx = full[wordW-1:0];
      expFlags.cry0 = full[2*wordW];
      expFlags.cry1 = full[2*wordW-1] ^ hiA[0] ^ hiB[0];
      expFlags.ovf = expFlags.cry0 ^ expFlags.cry1;
      checkRegs(regs, expRegs);
      checkFlags(flags, expFlags);
    end
    finishTest("long add", errBefore);
  endtask

  task automatic mqTest();
    int errBefore;
    word_t next;
    edpFlags_t fl;
    errBefore = errors;
    loadAr(randWord());
    loadBrAr(randWord());
    runStep(opWord(fnPassA, adaAR, adbBR, arHold, arxHold, mqLoad), '0);
    expRegs.mq = expRegs.ar;
    checkRegs(regs, expRegs);
    // New AR each step so the shifted-in carry varies
    repeat (6) begin
      next = randWord();
      fl = addFlags(expRegs.ar, expRegs.br, 1'b0);
      runStep(opWord(fnAdd, adaAR, adbBR, arExt, arxHold, mqShl), next);
      expRegs.mq = (expRegs.mq << 1) | word_t'(fl.cry0);
      expRegs.ar = next;
      expFlags = fl;
      checkRegs(regs, expRegs);
      checkFlags(flags, expFlags);
    end
    for (int s = 0; s < 2; s++) begin
      next = (s == 0) ? (randWord() | signBit) : (randWord() & ~signBit);
      loadAr(next);
      runStep(opWord(fnPassA, adaAR, adbBR, arHold, arxHold, mqLoad), '0);
      expRegs.mq = expRegs.ar;
      repeat (3) begin
        runStep(opWord(fnPassA, adaAR, adbBR, arHold, arxHold, mqShr), '0);
        expRegs.mq = (expRegs.mq >> 1) | (expRegs.mq & signBit);
        checkRegs(regs, expRegs);
      end
    end
    finishTest("MQ shift", errBefore);
  endtask

  task automatic fmTest();
    int errBefore;
    logic [fmAdrW-1:0] adrs [3];
    uword_u u;
    errBefore = errors;
    adrs = '{4'd3, 4'd9, 4'd14};
    for (int i = 0; i < 3; i++) begin
      loadAr(randWord());
      u = opWord(fnPassA, adaAR, adbBR, arHold, arxHold, mqHold);
      u.normal.fmAdr = adrs[i];
      u.normal.fmWriteL = 1'b1;
      u.normal.fmWriteR = 1'b1;
      runStep(u, '0);
      expFm[adrs[i]] = expRegs.ar;
    end
    // Left half only at the second address, right half only at the third
    for (int i = 1; i < 3; i++) begin
      loadAr(randWord());
      u = opWord(fnPassA, adaAR, adbBR, arHold, arxHold, mqHold);
      u.normal.fmAdr = adrs[i];
      u.normal.fmWriteL = (i == 1);
      u.normal.fmWriteR = (i == 2);
      runStep(u, '0);
      if (i == 1) begin
        expFm[adrs[i]] = (expFm[adrs[i]] & ~leftMask) | (expRegs.ar & leftMask);
      end else begin
        expFm[adrs[i]] = (expFm[adrs[i]] & leftMask) | (expRegs.ar & ~leftMask);
      end
    end
    for (int i = 0; i < 3; i++) begin
      u = opWord(fnPassA, adaAR, adbBR, arFM, arxHold, mqHold);
      u.normal.fmAdr = adrs[i];
      runStep(u, '0);
      expRegs.ar = expFm[adrs[i]];
      checkRegs(regs, expRegs);
      checkBit("fmParity", fmParity, ^expFm[adrs[i]]);
      diagRead(dsFM, adrs[i], expFm[adrs[i]], "ebusData (FM)");
      checkBit("fmParity", fmParity, ^expFm[adrs[i]]);
    end
    finishTest("fast memory", errBefore);
  endtask

  initial begin
    step = 1'b0;
    uword = '0;
    extData = '0;
    arstN = 1'b0;
    repeat (10) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    resetTest();
    loadMoveTest();
    aluTest();
    longAddTest();
    mqTest();
    fmTest();
    $display("%0d tests passed, %0d tests failed, %0d checks", testsPassed, testsFailed,
             checks);
    if (testsFailed == 0 && errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== logic/dataPath.sv ====
module dataPath
  import edpPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  input  logic      step,
  input  uword_u    uword,
  input  word_t     extData,
  output regView_t  regs,
  output edpFlags_t flags,
  output word_t     ebusData,
  output logic      ebusValid,
  output logic      fmParity
);

  edpCtl_t  ctl;
  diagReq_t diag;
  adOut_t   res;
  word_t    fmRd;

  uwordDecode uwordDecode_i (
    .clk   (clk),
    .arstN (arstN),
    .step  (step),
    .uword (uword),
    .ctl   (ctl),
    .diag  (diag)
  );

  adderPair adderPair_i (
    .ctl  (ctl),
    .regs (regs),
    .fm   (fmRd),
    .res  (res)
  );

  regBank regBank_i (
    .clk       (clk),
    .arstN     (arstN),
    .ctl       (ctl),
    .diag      (diag),
    .res       (res),
    .fm        (fmRd),
    .extData   (extData),
    .regs      (regs),
    .flags     (flags),
    .ebusData  (ebusData),
    .ebusValid (ebusValid)
  );

  // FM is always written from AR
  fastMem fastMem_i (
    .clk    (clk),
    .ctl    (ctl),
    .wrData (regs.ar),
    .rdData (fmRd),
    .parity (fmParity)
  );

endmodule

// ==== logic/fastMem.sv ====
module fastMem
  import edpPkg::*;
(
  input  logic    clk,
  input  edpCtl_t ctl,
  input  word_t   wrData,
  output word_t   rdData,
  output logic    parity
);

  word_t mem [fmDepth];

  // Halves are written independently
  always_ff @(posedge clk) begin
    if (ctl.doStep && ctl.fmWriteL) begin
      mem[ctl.fmAdr][0:halfW-1] <= wrData[0:halfW-1];
    end
    if (ctl.doStep && ctl.fmWriteR) begin
      mem[ctl.fmAdr][halfW:wordW-1] <= wrData[halfW:wordW-1];
    end
  end

  // Asynchronous read at the microword address
  assign rdData = mem[ctl.fmAdr];

  // Even parity over the whole word
  assign parity = ^rdData;

endmodule

// ==== logic/regBank.sv ====
module regBank
  import edpPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  input  edpCtl_t   ctl,
  input  diagReq_t  diag,
  input  adOut_t    res,
  input  word_t     fm,
  input  word_t     extData,
  output regView_t  regs,
  output edpFlags_t flags,
  output word_t     ebusData,
  output logic      ebusValid
);

  word_t arNext;
  word_t arxNext;
  word_t mqNext;
  word_t ebusSel;

  // AR load mux
  always_comb begin
    case (ctl.arSel)
      arAD:     arNext = res.ad;
      arADX:    arNext = res.adx;
      arADx2:   arNext = {res.ad[1:wordW-1], res.adx[0]};
      arADdiv4: arNext = {2'b00, res.ad[0:wordW-3]};
      arExt:    arNext = extData;
      arFM:     arNext = fm;
      default:  arNext = regs.ar;
    endcase
  end

  // ARX load mux
  always_comb begin
    case (ctl.arxSel)
      arxAD:   arxNext = res.ad;
      arxADX:  arxNext = res.adx;
      arxMQ:   arxNext = regs.mq;
      arxExt:  arxNext = extData;
      arxZero: arxNext = '0;
      default: arxNext = regs.arx;
    endcase
  end

  // MQ as universal shift register
  always_comb begin
    case (ctl.mqFunc)
      mqLoad:  mqNext = res.ad;
      mqShl:   mqNext = {regs.mq[1:wordW-1], res.cry0};
      mqShr:   mqNext = {regs.mq[0], regs.mq[0:wordW-2]};
      default: mqNext = regs.mq;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regs  <= '0;
      flags <= '0;
    end else if (ctl.doStep) begin
      regs.ar  <= arNext;
      regs.arx <= arxNext;
      regs.mq  <= mqNext;
      // BR and BRX take the old AR and ARX
      if (ctl.brLoad) begin
        regs.br <= regs.ar;
      end
      if (ctl.brxLoad) begin
        regs.brx <= regs.arx;
      end
      flags <= '{cry0: res.cry0, cry1: res.cry1, ovf: res.ovf};
    end
  end

  // Diagnostic readback source
  always_comb begin
    case (diag.src)
      dsAR:    ebusSel = regs.ar;
      dsBR:    ebusSel = regs.br;
      dsMQ:    ebusSel = regs.mq;
      dsFM:    ebusSel = fm;
      dsBRX:   ebusSel = regs.brx;
      dsARX:   ebusSel = regs.arx;
      dsADX:   ebusSel = res.adx;
      default: ebusSel = res.ad;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ebusData  <= '0;
      ebusValid <= 1'b0;
    end else begin
      ebusValid <= diag.valid;
      if (diag.valid) begin
        ebusData <= ebusSel;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!arstN)
    ctl.doStep |=> !ebusValid)
    else $error("ebusValid raised after a normal step");

  // Diagnostic reads leave the architectural state alone
  assert property (@(posedge clk) disable iff (!arstN)
    diag.valid |=> $stable(regs) && $stable(flags))
    else $error("Register changed on diagnostic step");

endmodule

// ==== logic/adderPair.sv ====
module adderPair
  import edpPkg::*;
(
  input  edpCtl_t  ctl,
  input  regView_t regs,
  input  word_t    fm,
  output adOut_t   res
);

  word_t ada;
  word_t adb;
  word_t adxa;
  word_t adxb;
  word_t adbOp;
  word_t adxbOp;
  logic [wordW+1:0] adSum;
  logic [wordW+1:0] adxSum;
  logic adCin;
  logic fnCin;
  logic isArith;
  logic [2*wordW-1:0] longExp;

  // Returns {carry out of bit 0, carry out of bit 1, sum}
  function automatic logic [wordW+1:0] addWord(word_t a, word_t b, logic cin);
    logic [wordW-1:0] lowSum;
    logic c0;
    logic s0;
    lowSum = {1'b0, a[1:wordW-1]} + {1'b0, b[1:wordW-1]} + wordW'(cin);
    s0 = a[0] ^ b[0] ^ lowSum[wordW-1];
    c0 = (a[0] & b[0]) | ((a[0] ^ b[0]) & lowSum[wordW-1]);
    return {c0, lowSum[wordW-1], s0, lowSum[wordW-2:0]};
  endfunction

  function automatic word_t aluWord(adFunc_e f, word_t a, word_t b,
                                    logic [wordW+1:0] sum);
    word_t r;
    case (f)
      fnAnd:   r = a & b;
      fnOr:    r = a | b;
      fnXor:   r = a ^ b;
      fnPassA: r = a;
      fnPassB: r = b;
      default: r = sum[wordW-1:0];
    endcase
    return r;
  endfunction

  // Operand muxes
  always_comb begin
    case (ctl.adaSel)
      adaAR:   ada = regs.ar;
      adaARX:  ada = regs.arx;
      adaMQ:   ada = regs.mq;
      default: ada = '0;
    endcase
    adxa = (ctl.adaSel == adaZero) ? '0 : regs.arx;

    case (ctl.adbSel)
      adbFM: begin
        adb  = fm;
        adxb = {ctl.magic, {(wordW - magicW){1'b0}}};
      end
      adbBRx2: begin
        adb  = {regs.br[1:wordW-1], regs.brx[0]};
        adxb = {regs.brx[1:wordW-1], 1'b0};
      end
      adbBR: begin
        adb  = regs.br;
        adxb = regs.brx;
      end
      default: begin
        adb  = {regs.ar[2:wordW-1], regs.arx[0:1]};
        adxb = {regs.arx[2:wordW-1], 2'b00};
      end
    endcase
  end

  always_comb begin
    isArith = ctl.adFunc inside {fnAdd, fnAddOne, fnSub};
    fnCin   = (ctl.adFunc == fnAddOne) || (ctl.adFunc == fnSub);
    adbOp   = (ctl.adFunc == fnSub) ? ~adb : adb;
    adxbOp  = (ctl.adFunc == fnSub) ? ~adxb : adxb;

    // ADX is the low half, so its carry feeds AD in long mode
    adxSum = addWord(adxa, adxbOp, fnCin);
    adCin  = ctl.long ? adxSum[wordW+1] : fnCin;
    adSum  = addWord(ada, adbOp, adCin);

    res.ad   = aluWord(ctl.adFunc, ada, adb, adSum);
    res.adx  = aluWord(ctl.adFunc, adxa, adxb, adxSum);
    res.cry0 = isArith && adSum[wordW+1];
    res.cry1 = isArith && adSum[wordW];
    res.ovf  = res.cry0 ^ res.cry1;

    // Chained halves must match a flat 72-bit add
    longExp = {ada, adxa} + {adb, adxb};
    if (ctl.long && ctl.adFunc == fnAdd) begin
      assert ({res.ad, res.adx} == longExp)
        else $error("Long add mismatch across AD/ADX boundary");
    end
  end

endmodule

// ==== logic/uwordDecode.sv ====
module uwordDecode
  import edpPkg::*;
(
  input  logic     clk,
  input  logic     arstN,
  input  logic     step,
  input  uword_u   uword,
  output edpCtl_t  ctl,
  output diagReq_t diag
);

  logic isDiag;

  // Same bit position in both readings
  assign isDiag = uword.diag.fmt;

  always_comb begin
    ctl.doStep  = step && !isDiag;
    ctl.adFunc  = uword.normal.adFunc;
    ctl.long    = uword.normal.long;
    ctl.adaSel  = uword.normal.adaSel;
    ctl.adbSel  = uword.normal.adbSel;
    ctl.arSel   = uword.normal.arSel;
    ctl.arxSel  = uword.normal.arxSel;
    ctl.mqFunc  = uword.normal.mqFunc;
    ctl.brLoad  = uword.normal.brLoad;
    ctl.brxLoad = uword.normal.brxLoad;
    ctl.magic   = uword.normal.magic;

    // Write enables sit in the diagnostic padding
    ctl.fmWriteL = uword.normal.fmWriteL;
    ctl.fmWriteR = uword.normal.fmWriteR;

    // Diagnostic reads carry their own FM address
    if (isDiag) begin
      ctl.fmAdr = uword.diag.fmAdr;
    end else begin
      ctl.fmAdr = uword.normal.fmAdr;
    end
  end

  assign diag.valid = step && isDiag;
  assign diag.src   = uword.diag.diagSrc;

  // No FM write may come out of a diagnostic microword
  assert property (@(posedge clk) disable iff (!arstN)
    diag.valid |-> !(ctl.fmWriteL || ctl.fmWriteR))
    else $error("FM write enable on diagnostic step");

  // Selectors must be driven for a normal step
  assert property (@(posedge clk) disable iff (!arstN)
    ctl.doStep |-> !$isunknown({ctl.adFunc, ctl.long, ctl.adaSel, ctl.adbSel,
                                ctl.arSel, ctl.arxSel, ctl.mqFunc,
                                ctl.brLoad, ctl.brxLoad}))
    else $error("Unknown selector on normal step");

endmodule

// ==== logic/edpPkg.sv ====
package edpPkg;

  // Data path geometry
  localparam int wordW   = 36;
  localparam int halfW   = wordW / 2;
  localparam int fmAdrW  = 4;
  localparam int fmDepth = 1 << fmAdrW;
  localparam int magicW  = 9;

  // Bit 0 is the most significant bit
  typedef logic [0:wordW-1] word_t;

  typedef enum logic [2:0] {
    fnAdd,
    fnAddOne,
    fnSub,
    fnAnd,
    fnOr,
    fnXor,
    fnPassA,
    fnPassB
  } adFunc_e;

  // adaZero also forces ADXA to zero
  typedef enum logic [1:0] {
    adaAR,
    adaARX,
    adaMQ,
    adaZero
  } adaSel_e;

  typedef enum logic [1:0] {
    adbFM,
    adbBRx2,
    adbBR,
    adbARx4
  } adbSel_e;

  typedef enum logic [2:0] {
    arHold,
    arAD,
    arADX,
    arADx2,
    arADdiv4,
    arExt,
    arFM
  } arSel_e;

  typedef enum logic [2:0] {
    arxHold,
    arxAD,
    arxADX,
    arxMQ,
    arxExt,
    arxZero
  } arxSel_e;

  typedef enum logic [1:0] {
    mqLoad,
    mqShl,
    mqShr,
    mqHold
  } mqFunc_e;

  // Same order as the EBUS diagnostic read function
  typedef enum logic [2:0] {
    dsAR,
    dsBR,
    dsMQ,
    dsFM,
    dsBRX,
    dsARX,
    dsADX,
    dsAD
  } diagSrc_e;

  // 34 field bits plus 6 spare
  typedef struct packed {
    logic               fmt;
    adFunc_e            adFunc;
    logic               long;
    adaSel_e            adaSel;
    adbSel_e            adbSel;
    arSel_e             arSel;
    arxSel_e            arxSel;
    mqFunc_e            mqFunc;
    logic               brLoad;
    logic               brxLoad;
    logic               fmWriteL;
    logic               fmWriteR;
    logic [fmAdrW-1:0]  fmAdr;
    logic [magicW-1:0]  magic;
    logic [5:0]         pad;
  } uwNormal_t;

  typedef struct packed {
    logic               fmt;
    diagSrc_e           diagSrc;
    logic [fmAdrW-1:0]  fmAdr;
    logic [31:0]        pad;
  } uwDiag_t;

  // fmt is the top bit of both readings
  typedef union packed {
    uwNormal_t normal;
    uwDiag_t   diag;
  } uword_u;

  typedef struct packed {
    logic               doStep;
    adFunc_e            adFunc;
    logic               long;
    adaSel_e            adaSel;
    adbSel_e            adbSel;
    arSel_e             arSel;
    arxSel_e            arxSel;
    mqFunc_e            mqFunc;
    logic               brLoad;
    logic               brxLoad;
    logic               fmWriteL;
    logic               fmWriteR;
    logic [fmAdrW-1:0]  fmAdr;
    logic [magicW-1:0]  magic;
  } edpCtl_t;

  typedef struct packed {
    logic     valid;
    diagSrc_e src;
  } diagReq_t;

  typedef struct packed {
    word_t ad;
    word_t adx;
    logic  cry0;
    logic  cry1;
    logic  ovf;
  } adOut_t;

  typedef struct packed {
    logic cry0;
    logic cry1;
    logic ovf;
  } edpFlags_t;

  typedef struct packed {
    word_t ar;
    word_t arx;
    word_t br;
    word_t brx;
    word_t mq;
  } regView_t;

endpackage
